//--- qdr_controller.f
design/qdr_cfg_pkg.sv
design/qdr_bus_pkg.sv
design/qdrc_wr.sv
design/qdrc_rd.sv
design/qdrc_addr_arb.sv
design/qdrc_phy.sv
design/qdr_controller.sv
sim/qdr_sram_model.sv
sim/tb_qdr_controller.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_qdr_controller \
  -f qdr_controller.f -o tb_qdr_controller \
  && ./obj_dir/tb_qdr_controller | tee sim.log \
  && grep -qx "Simulation finished: PASS" sim.log \
  || { echo "simulation failed"; exit 1; }

echo "simulation passed"

//--- sim/tb_qdr_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qdr_controller;

  logic                   clk0;
  logic                   rst_n;
  logic                   usr_wr_strb;
  qdr_bus_pkg::wr_req_t   usr_wr_req;
  logic                   usr_rd_strb;
  qdr_cfg_pkg::qdr_addr_t usr_rd_addr;
  qdr_cfg_pkg::beat_t     qdr_q;
  qdr_bus_pkg::qdr_pins_t qdr_pins;
  qdr_cfg_pkg::beat_t     usr_rd_data;
  logic                   usr_rd_dvld;
  logic                   phy_rdy;
  logic                   ovf;

  // reference memory aliased like the sram
  qdr_cfg_pkg::beat_t ref_mem [1024];
  // expected read beats in return order
  qdr_cfg_pkg::beat_t exp_q [$];
  qdr_cfg_pkg::beat_t exp_beat;
  int errors = 0;
  int base_err = 0;
  int fails = 0;
  int w_low = 0;
  int r_low = 0;
  int dvld_cnt = 0;
  int max_out = 0;

  qdr_controller dut_i (
    .clk0        (clk0),
    .rst_n       (rst_n),
    .usr_wr_strb (usr_wr_strb),
    .usr_wr_req  (usr_wr_req),
    .usr_rd_strb (usr_rd_strb),
    .usr_rd_addr (usr_rd_addr),
    .qdr_q       (qdr_q),
    .qdr_pins    (qdr_pins),
    .usr_rd_data (usr_rd_data),
    .usr_rd_dvld (usr_rd_dvld),
    .phy_rdy     (phy_rdy),
    .ovf         (ovf)
  );

  qdr_sram_model sram_i (
    .clk0 (clk0),
    .pins (qdr_pins),
    .q    (qdr_q)
  );

  initial begin
    clk0 = 1'b0;
    forever #5 clk0 = ~clk0;
  end

  // ======================================
  // helpers
  // ======================================
  task automatic check_val(input string name, input logic [71:0] expv,
                           input logic [71:0] actv);
    assert (actv === expv) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, expv, actv);
      errors++;
    end
  endtask

  function automatic qdr_cfg_pkg::beat_t rand_beat();
    return qdr_cfg_pkg::beat_t'({$urandom, $urandom, $urandom});
  endfunction

  // few word indices so traffic collides
  // upper bits stay random
  function automatic qdr_cfg_pkg::qdr_addr_t pool_addr();
    qdr_cfg_pkg::qdr_addr_t a;
    a = qdr_cfg_pkg::qdr_addr_t'($urandom);
    a[9:0] = 10'($urandom_range(0, 7) * 97);
    return a;
  endfunction

  // 9-bit lane merge with active high enables
  task automatic apply_write(input qdr_bus_pkg::wr_req_t req);
    for (int l = 0; l < 8; l++) begin
      if (req.ben[l]) begin
        ref_mem[req.addr[9:0]][l*9 +: 9] = req.data[l*9 +: 9];
      end
    end
  endtask

  // one user cycle
  // read side of a pair reaches the model first
  task automatic drive_cycle(input logic wr, input qdr_bus_pkg::wr_req_t req,
                             input logic rd, input qdr_cfg_pkg::qdr_addr_t raddr);
    usr_wr_strb = wr;
    usr_wr_req  = req;
    usr_rd_strb = rd;
    usr_rd_addr = raddr;
    if (rd) begin
      exp_q.push_back(ref_mem[raddr[9:0]]);
    end
    if (wr) begin
      apply_write(req);
    end
    @(posedge clk0);
    #1;
    usr_wr_strb = 1'b0;
    usr_rd_strb = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < limit)) begin
      @(posedge clk0);
      n++;
    end
    #1;
    assert (exp_q.size() == 0) else begin
      $display("ERROR: %0d reads never returned within %0d cycles", exp_q.size(), limit);
      errors++;
    end
    // margin for any stray valid pulse
    repeat (4) @(posedge clk0);
    #1;
  endtask

  task automatic report_test(input int num, input string name);
    if (errors == base_err) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: FAILED with %0d errors", num, name, errors - base_err);
      fails++;
    end
    base_err = errors;
  endtask

  // ======================================
  // output monitor at mid cycle
  // ======================================
  always @(negedge clk0) begin
    if (rst_n) begin
      if (!qdr_pins.w_n) begin
        w_low++;
      end
      if (!qdr_pins.r_n) begin
        r_low++;
      end
      if (usr_rd_dvld) begin
        dvld_cnt++;
        assert (exp_q.size() != 0) else begin
          $display("ERROR: read data valid with no read outstanding");
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_beat = exp_q.pop_front();
          check_val("usr_rd_data", 72'(exp_beat), 72'(usr_rd_data));
        end
      end
      if (exp_q.size() > max_out) begin
        max_out = exp_q.size();
      end
    end
  end

  // ======================================
  // stimulus
  // ======================================
  initial begin
    int unsigned            seed_dummy;
    int                     i;
    int                     timer;
    int                     n_rd;
    logic                   wr;
    logic                   rd;
    logic                   prev_pair;
    qdr_bus_pkg::wr_req_t   req;
    qdr_cfg_pkg::qdr_addr_t raddr;
    qdr_cfg_pkg::qdr_addr_t addrs [8];

    seed_dummy  = $urandom(2);
    rst_n       = 1'b0;
    usr_wr_strb = 1'b0;
    usr_wr_req  = '0;
    usr_rd_strb = 1'b0;
    usr_rd_addr = '0;
    req         = '0;
    // same index dependent contents as the sram model
    for (i = 0; i < 1024; i++) begin
      ref_mem[i] = qdr_cfg_pkg::beat_t'({7{10'(i)}});
    end
    repeat (16) @(posedge clk0);
    #1;
    rst_n = 1'b1;

    // idle pins after reset
    check_val("qdr_pins.w_n", 72'(1), 72'(qdr_pins.w_n));
    check_val("qdr_pins.r_n", 72'(1), 72'(qdr_pins.r_n));
    check_val("usr_rd_dvld", 72'(0), 72'(usr_rd_dvld));
    // strobes during calibration must be dropped
    timer = 0;
    while (!phy_rdy && (timer < 64)) begin
      usr_wr_strb = 1'b1;
      usr_wr_req  = '{addr: qdr_cfg_pkg::qdr_addr_t'($urandom), data: rand_beat(), ben: '1};
      usr_rd_strb = 1'b1;
      usr_rd_addr = qdr_cfg_pkg::qdr_addr_t'($urandom);
      @(posedge clk0);
      #1;
      timer++;
    end
    usr_wr_strb = 1'b0;
    usr_rd_strb = 1'b0;
    assert (phy_rdy) else begin
      $display("ERROR: phy_rdy did not rise within 64 cycles of reset release");
      errors++;
    end
    repeat (6) @(posedge clk0);
    #1;
    check_val("w_n low cycles", 72'(0), 72'(w_low));
    check_val("r_n low cycles", 72'(0), 72'(r_low));
    report_test(1, "reset and calibration");

    for (i = 0; i < 8; i++) begin
      addrs[i] = qdr_cfg_pkg::qdr_addr_t'($urandom);
      req = '{addr: addrs[i], data: rand_beat(), ben: '1};
      drive_cycle(1'b1, req, 1'b0, '0);
    end
    for (i = 0; i < 8; i++) begin
      drive_cycle(1'b0, req, 1'b1, addrs[i]);
    end
    wait_drain(64);
    report_test(2, "full writes then reads");

    // full write, partial overwrite, read back
    for (i = 0; i < 6; i++) begin
      req = '{addr: qdr_cfg_pkg::qdr_addr_t'($urandom), data: rand_beat(), ben: '1};
      drive_cycle(1'b1, req, 1'b0, '0);
      req.data = rand_beat();
      req.ben  = qdr_cfg_pkg::ben_t'($urandom);
      drive_cycle(1'b1, req, 1'b0, '0);
      drive_cycle(1'b0, req, 1'b1, req.addr);
    end
    wait_drain(64);
    report_test(3, "partial byte enables");

    // a pair cycle is always followed by a quiet one
    prev_pair = 1'b0;
    for (i = 0; i < 80; i++) begin
      wr = !prev_pair && ($urandom_range(0, 1) == 1);
      rd = !prev_pair && ($urandom_range(0, 1) == 1);
      req = '{addr: pool_addr(), data: rand_beat(), ben: qdr_cfg_pkg::ben_t'($urandom)};
      raddr = ($urandom_range(0, 3) != 0) ? req.addr : pool_addr();
      drive_cycle(wr, req, rd, raddr);
      prev_pair = wr && rd;
    end
    wait_drain(64);
    check_val("ovf", 72'(0), 72'(ovf));
    report_test(4, "mixed traffic");

    n_rd    = dvld_cnt;
    max_out = 0;
    for (i = 0; i < 12; i++) begin
      drive_cycle(1'b0, req, 1'b1, pool_addr());
    end
    wait_drain(64);
    check_val("usr_rd_dvld pulses", 72'(12), 72'(dvld_cnt - n_rd));
    assert (max_out >= 3) else begin
      $display("ERROR: only %0d reads were in flight at once", max_out);
      errors++;
    end
    report_test(5, "back to back reads");

    $display("tests 5 failed %0d errors %0d", fails, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/qdr_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_sram_model (
  input  wire                    clk0,
  input  qdr_bus_pkg::qdr_pins_t pins,
  output qdr_cfg_pkg::beat_t     q
);

  // only the low sa bits select a word
  // upper sa bits alias
  localparam int idx_w  = 10;
  localparam int depth  = 1 << idx_w;
  localparam int lanes  = 2 * qdr_cfg_pkg::bw_w;
  localparam int lane_w = (2 * qdr_cfg_pkg::data_w) / lanes;

  qdr_cfg_pkg::beat_t mem [depth];
  // read data in flight toward q
  qdr_cfg_pkg::beat_t rd_pipe [qdr_cfg_pkg::rd_lat];
  logic [idx_w-1:0]   idx;

  assign idx = pins.sa[idx_w-1:0];

  initial begin
    // fill pattern varies with every index bit
    for (int i = 0; i < depth; i++) begin
      mem[i] = qdr_cfg_pkg::beat_t'({7{idx_w'(i)}});
    end
    for (int s = 0; s < qdr_cfg_pkg::rd_lat; s++) begin
      rd_pipe[s] = '1;
    end
  end

  // ======================================
  // pin sampling
  // ======================================
  always @(posedge clk0) begin
    // write lanes with bw_n low only
    if (!pins.w_n) begin
      for (int l = 0; l < lanes; l++) begin
        if (!pins.bw_n[l]) begin
          mem[idx][l*lane_w +: lane_w] <= pins.d[l*lane_w +: lane_w];
        end
      end
    end
    // idle beats read as all ones
    if (!pins.r_n) begin
      rd_pipe[0] <= mem[idx];
    end else begin
      rd_pipe[0] <= '1;
    end
    for (int s = 1; s < qdr_cfg_pkg::rd_lat; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  // valid rd_lat cycles after r_n low
  assign q = rd_pipe[qdr_cfg_pkg::rd_lat-1];

endmodule

`default_nettype wire

//--- design/qdr_controller.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_controller (
  input  wire                    clk0,
  input  wire                    rst_n,
  input  wire                    usr_wr_strb,
  input  qdr_bus_pkg::wr_req_t   usr_wr_req,
  input  wire                    usr_rd_strb,
  input  qdr_cfg_pkg::qdr_addr_t usr_rd_addr,
  input  qdr_cfg_pkg::beat_t     qdr_q,
  output qdr_bus_pkg::qdr_pins_t qdr_pins,
  output qdr_cfg_pkg::beat_t     usr_rd_data,
  output logic                   usr_rd_dvld,
  output logic                   phy_rdy,
  output logic                   ovf
);

  // ======================================
  // internal wiring
  // ======================================
  logic                  wr_strb;
  logic                  rd_strb;
  logic                  wr_pend;
  logic                  wr_grant;
  logic                  wr_ovf;
  qdr_bus_pkg::wr_req_t  wr_head;
  logic                  rd_pend;
  logic                  rd_grant;
  logic                  rd_ovf;
  qdr_bus_pkg::rd_req_t  rd_head;
  qdr_bus_pkg::bus_cmd_t cmd;
  qdr_cfg_pkg::beat_t    q_cap;

  // strobes during calibration are dropped
  assign wr_strb = usr_wr_strb && phy_rdy;
  assign rd_strb = usr_rd_strb && phy_rdy;

  // either queue overflowing
  assign ovf = wr_ovf || rd_ovf;

  // write path
  qdrc_wr wr_i (
    .clk0  (clk0),
    .rst_n (rst_n),
    .strb  (wr_strb),
    .req   (usr_wr_req),
    .grant (wr_grant),
    .pend  (wr_pend),
    .head  (wr_head),
    .ovf   (wr_ovf)
  );

  // read path and return timing
  qdrc_rd rd_i (
    .clk0    (clk0),
    .rst_n   (rst_n),
    .strb    (rd_strb),
    .addr    (usr_rd_addr),
    .grant   (rd_grant),
    .q_cap   (q_cap),
    .pend    (rd_pend),
    .head    (rd_head),
    .ovf     (rd_ovf),
    .rd_data (usr_rd_data),
    .rd_dvld (usr_rd_dvld)
  );

  // one address bus, reads win
  qdrc_addr_arb arb_i (
    .clk0     (clk0),
    .rst_n    (rst_n),
    .phy_rdy  (phy_rdy),
    .wr_pend  (wr_pend),
    .wr_head  (wr_head),
    .rd_pend  (rd_pend),
    .rd_head  (rd_head),
    .wr_grant (wr_grant),
    .rd_grant (rd_grant),
    .cmd      (cmd)
  );

  qdrc_phy phy_i (
    .clk0    (clk0),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .q       (qdr_q),
    .pins    (qdr_pins),
    .q_cap   (q_cap),
    .phy_rdy (phy_rdy)
  );

endmodule

`default_nettype wire

//--- design/qdrc_phy.sv
`timescale 1ns/1ps
`default_nettype none

module qdrc_phy (
  input  wire                    clk0,
  input  wire                    rst_n,
  input  qdr_bus_pkg::bus_cmd_t  cmd,
  input  qdr_cfg_pkg::beat_t     q,
  output qdr_bus_pkg::qdr_pins_t pins,
  output qdr_cfg_pkg::beat_t     q_cap,
  output logic                   phy_rdy
);

  typedef enum logic {cal_run, cal_done} cal_st_t;

  // ======================================
  // reset retiming and calibration
  // ======================================
  // async assert, release synced to clk0
  logic [1:0]            rst_sync;
  logic                  phy_rst_n;
  cal_st_t               cal_st;
  qdr_cfg_pkg::cal_cnt_t cal_cnt;

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign phy_rst_n = rst_sync[1];

  // fixed wait in place of real training
  always_ff @(posedge clk0 or negedge phy_rst_n) begin
    if (!phy_rst_n) begin
      cal_st  <= cal_run;
      cal_cnt <= '0;
    end else if (cal_st == cal_run) begin
      cal_cnt <= cal_cnt + 1'b1;
      if (cal_cnt == qdr_cfg_pkg::cal_last) begin
        cal_st <= cal_done;
      end
    end
  end

  assign phy_rdy = (cal_st == cal_done);

  // ======================================
  // pin formatting
  // ======================================
  qdr_cfg_pkg::half_t     d_rise;
  qdr_cfg_pkg::half_t     d_fall;
  qdr_cfg_pkg::half_ben_t bw_rise;
  qdr_cfg_pkg::half_ben_t bw_fall;
  qdr_cfg_pkg::half_t     q_rise;
  qdr_cfg_pkg::half_t     q_fall;
  qdr_cfg_pkg::beat_t     d_q;
  qdr_cfg_pkg::qdr_addr_t sa_q;
  logic                   w_n_q;
  logic                   r_n_q;
  qdr_cfg_pkg::ben_t      bw_n_q;

  // edge halves, both on clk0 here
  assign d_rise  = cmd.data[qdr_cfg_pkg::data_w-1:0];
  assign d_fall  = cmd.data[2*qdr_cfg_pkg::data_w-1:qdr_cfg_pkg::data_w];
  assign bw_rise = cmd.ben[qdr_cfg_pkg::bw_w-1:0];
  assign bw_fall = cmd.ben[2*qdr_cfg_pkg::bw_w-1:qdr_cfg_pkg::bw_w];
  assign q_rise  = q[qdr_cfg_pkg::data_w-1:0];
  assign q_fall  = q[2*qdr_cfg_pkg::data_w-1:qdr_cfg_pkg::data_w];

  // strobes idle high
  always_ff @(posedge clk0 or negedge phy_rst_n) begin
    if (!phy_rst_n) begin
      w_n_q  <= 1'b1;
      r_n_q  <= 1'b1;
      bw_n_q <= '1;
    end else begin
      w_n_q  <= !cmd.wr;
      r_n_q  <= !cmd.rd;
      // lanes masked off unless writing
      bw_n_q <= cmd.wr ? ~{bw_fall, bw_rise} : '1;
    end
  end

  always_ff @(posedge clk0) begin
    d_q   <= {d_fall, d_rise};
    sa_q  <= cmd.addr;
    q_cap <= {q_fall, q_rise};
  end

  assign pins = '{d: d_q, sa: sa_q, w_n: w_n_q, r_n: r_n_q, bw_n: bw_n_q};

endmodule

`default_nettype wire

//--- design/qdrc_addr_arb.sv
`timescale 1ns/1ps
`default_nettype none

module qdrc_addr_arb (
  input  wire                   clk0,
  input  wire                   rst_n,
  input  wire                   phy_rdy,
  input  wire                   wr_pend,
  input  qdr_bus_pkg::wr_req_t  wr_head,
  input  wire                   rd_pend,
  input  qdr_bus_pkg::rd_req_t  rd_head,
  output logic                  wr_grant,
  output logic                  rd_grant,
  output qdr_bus_pkg::bus_cmd_t cmd
);

  logic                   cmd_wr;
  logic                   cmd_rd;
  qdr_cfg_pkg::qdr_addr_t cmd_addr;
  qdr_cfg_pkg::beat_t     cmd_data;
  qdr_cfg_pkg::ben_t      cmd_ben;

  // ======================================
  // grant decision
  // ======================================
  // reads first, writes only on a read-free cycle
  assign rd_grant = phy_rdy && rd_pend;
  assign wr_grant = phy_rdy && wr_pend && !rd_pend;

  // command strobes
  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      cmd_wr <= 1'b0;
      cmd_rd <= 1'b0;
    end else begin
      cmd_wr <= wr_grant;
      cmd_rd <= rd_grant;
    end
  end

  // winner's payload onto the bus
  always_ff @(posedge clk0) begin
    if (rd_grant) begin
      cmd_addr <= rd_head.addr;
    end else if (wr_grant) begin
      cmd_addr <= wr_head.addr;
    end
    // data and enables only matter for writes
    if (wr_grant) begin
      cmd_data <= wr_head.data;
      cmd_ben  <= wr_head.ben;
    end
  end

  assign cmd = '{wr: cmd_wr, rd: cmd_rd, addr: cmd_addr, data: cmd_data, ben: cmd_ben};

endmodule

`default_nettype wire

//--- design/qdrc_rd.sv
`timescale 1ns/1ps
`default_nettype none

module qdrc_rd (
  input  wire                    clk0,
  input  wire                    rst_n,
  input  wire                    strb,
  input  qdr_cfg_pkg::qdr_addr_t addr,
  input  wire                    grant,
  input  qdr_cfg_pkg::beat_t     q_cap,
  output logic                   pend,
  output qdr_bus_pkg::rd_req_t   head,
  output logic                   ovf,
  output qdr_cfg_pkg::beat_t     rd_data,
  output logic                   rd_dvld
);

  // ======================================
  // request queue
  // ======================================
  qdr_bus_pkg::rd_req_t mem [qdr_cfg_pkg::q_depth];

  qdr_cfg_pkg::q_ptr_t wr_ptr;
  qdr_cfg_pkg::q_ptr_t rd_ptr;
  qdr_cfg_pkg::q_cnt_t count;
  logic                full;
  logic                push;

  assign full = (count == qdr_cfg_pkg::q_full_cnt);
  assign push = strb && (!full || grant);

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == qdr_cfg_pkg::q_ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (grant) begin
        rd_ptr <= (rd_ptr == qdr_cfg_pkg::q_ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, grant})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (strb && full && !grant) begin
        ovf <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk0) begin
    if (push) begin
      mem[wr_ptr].addr <= addr;
    end
  end

  assign pend = (count != '0);
  assign head = mem[rd_ptr];

  // ======================================
  // return timing
  // ======================================
  // grant delayed once, lines up with cmd.rd
  logic                           rd_launch;
  // stage 0 is the cycle r_n is low at the pins
  logic [qdr_cfg_pkg::rd_lat+1:0] lat_pipe;

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      rd_launch <= 1'b0;
      lat_pipe  <= '0;
      rd_dvld   <= 1'b0;
    end else begin
      rd_launch <= grant;
      lat_pipe  <= {lat_pipe[qdr_cfg_pkg::rd_lat:0], rd_launch};
      // last stage means q_cap holds this read
      rd_dvld   <= lat_pipe[qdr_cfg_pkg::rd_lat+1];
    end
  end

  // hold last beat between pulses
  always_ff @(posedge clk0) begin
    if (lat_pipe[qdr_cfg_pkg::rd_lat+1]) begin
      rd_data <= q_cap;
    end
  end

endmodule

`default_nettype wire

//--- design/qdrc_wr.sv
`timescale 1ns/1ps
`default_nettype none

module qdrc_wr (
  input  wire                  clk0,
  input  wire                  rst_n,
  input  wire                  strb,
  input  qdr_bus_pkg::wr_req_t req,
  input  wire                  grant,
  output logic                 pend,
  output qdr_bus_pkg::wr_req_t head,
  output logic                 ovf
);

  // small fifo of pending writes
  qdr_bus_pkg::wr_req_t mem [qdr_cfg_pkg::q_depth];

  qdr_cfg_pkg::q_ptr_t wr_ptr;
  qdr_cfg_pkg::q_ptr_t rd_ptr;
  qdr_cfg_pkg::q_cnt_t count;
  logic                full;
  logic                push;
  logic                pop;

  assign full = (count == qdr_cfg_pkg::q_full_cnt);
  // a pop in the same cycle frees the slot
  assign push = strb && (!full || grant);
  // arbiter only grants while pend is high
  assign pop  = grant;

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == qdr_cfg_pkg::q_ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == qdr_cfg_pkg::q_ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky, request is lost
      if (strb && full && !grant) begin
        ovf <= 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk0) begin
    if (push) begin
      mem[wr_ptr] <= req;
    end
  end

  assign pend = (count != '0);
  assign head = mem[rd_ptr];

endmodule

`default_nettype wire

//--- design/qdr_bus_pkg.sv
`default_nettype none

package qdr_bus_pkg;

  // ======================================
  // user requests
  // ======================================
  // one complete user write
  typedef struct packed {
    qdr_cfg_pkg::qdr_addr_t addr;
    qdr_cfg_pkg::beat_t     data;
    qdr_cfg_pkg::ben_t      ben;
  } wr_req_t;

  // reads carry only the address
  typedef struct packed {
    qdr_cfg_pkg::qdr_addr_t addr;
  } rd_req_t;

  // ======================================
  // shared bus and pins
  // ======================================
  // single command per cycle, wr and rd never both set
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    qdr_cfg_pkg::qdr_addr_t addr;
    qdr_cfg_pkg::beat_t     data;
    qdr_cfg_pkg::ben_t      ben;
  } bus_cmd_t;

  // sram outputs, strobes and lane enables active low
  typedef struct packed {
    qdr_cfg_pkg::beat_t     d;
    qdr_cfg_pkg::qdr_addr_t sa;
    logic                   w_n;
    logic                   r_n;
    qdr_cfg_pkg::ben_t      bw_n;
  } qdr_pins_t;

endpackage

`default_nettype wire

//--- design/qdr_cfg_pkg.sv
`default_nettype none

package qdr_cfg_pkg;

  // ======================================
  // sram geometry
  // ======================================
  // pin data width, one edge only
  localparam int data_w = 36;
  // 9-bit byte lanes per pin beat
  localparam int bw_w = 4;
  localparam int addr_w = 20;

  // ======================================
  // latencies and calibration
  // ======================================
  // r_n low to q valid at the pins
  localparam int rd_lat = 2;
  // cycles after retimed reset release
  localparam int cal_wait = 8;
  localparam int cal_cnt_w = (cal_wait > 1) ? $clog2(cal_wait) : 1;

  // request queue depth, both paths
  localparam int q_depth = 2;
  localparam int q_ptr_w = (q_depth > 1) ? $clog2(q_depth) : 1;
  localparam int q_cnt_w = $clog2(q_depth + 1);

  typedef logic [addr_w-1:0]   qdr_addr_t;
  // one clock edge worth of data
  typedef logic [data_w-1:0]   half_t;
  typedef logic [bw_w-1:0]     half_ben_t;
  // rise half sits in the low bits
  typedef logic [2*data_w-1:0] beat_t;
  // active high on the user side
  typedef logic [2*bw_w-1:0]   ben_t;

  typedef logic [q_ptr_w-1:0]   q_ptr_t;
  typedef logic [q_cnt_w-1:0]   q_cnt_t;
  typedef logic [cal_cnt_w-1:0] cal_cnt_t;

  // wrap and limit values, sized to their counters
  localparam q_ptr_t   q_ptr_last = q_ptr_t'(q_depth - 1);
  localparam q_cnt_t   q_full_cnt = q_cnt_t'(q_depth);
  localparam cal_cnt_t cal_last   = cal_cnt_t'(cal_wait - 1);

endpackage

`default_nettype wire
